//--- list.f
+incdir+.
fc_irq_pkg.sv
fc_irq_cfg_regs.sv
event_to_level.sv
fc_timer.sv
irq_arbiter.sv
irq_notify_fsm.sv
fc_irq_subsystem.sv
tb_fc_irq_subsystem.sv

//--- Bender.yml
package:
  name: fc_irq_subsystem

export_include_dirs:
  - .

sources:
  - fc_irq_pkg.sv
  - fc_irq_cfg_regs.sv
  - event_to_level.sv
  - fc_timer.sv
  - irq_arbiter.sv
  - irq_notify_fsm.sv
  - fc_irq_subsystem.sv
  - target: test
    files:
      - tb_fc_irq_subsystem.sv

//--- tb_fc_irq_subsystem.sv
/*
 * Testbench for the interrupt front end
 * Mirrors configuration and sources, predicts every offer and acknowledges it
 */
`timescale 1ns/1ps
`default_nettype none

`include "fc_irq_cfg.svh"

module tb_fc_irq_subsystem;

    import fc_irq_pkg::*;

    localparam int unsigned SEED = 32'h95ca_b3fd;
    // About 800 cycles for all six tests
    localparam int CYCLE_LIMIT = 2000;

    // Expected arbiter result for one cycle
    typedef struct packed {
        logic     valid;
        irq_req_t req;
    } exp_t;

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    cfg_wr_t     cfg;
    logic        event_valid_i;
    event_id_t   event_data_i;
    logic        event_ready_o;
    logic [31:0] events_i;
    logic [2:0]  ext_irq_i;
    logic        irq_ack_i;
    logic        irq_valid_o;
    src_id_t     irq_id_o;
    irq_level_t  irq_level_o;

    // Mirrored configuration and sources
    logic        en_m [`FC_N_SRC];
    irq_level_t  lvl_m [`FC_N_SRC];
    logic [31:0] ev_m;
    logic [2:0]  ext_m;
    logic        soc_pend;
    logic        tmr_pend;
    event_id_t   watch_m;

    exp_t        hist1;
    exp_t        hist2;
    logic        valid_q;
    logic        hold_ack;
    int          ack_wait;
    int          offer_cnt;
    src_id_t     last_id;
    irq_level_t  last_lvl;
    int          err_cnt;
    int          cyc = 0;
    int unsigned seed_val;

    fc_irq_subsystem fc_irq_subsystem_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .cfg_i         (cfg),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .event_ready_o (event_ready_o),
        .events_i      (events_i),
        .ext_irq_i     (ext_irq_i),
        .irq_ack_i     (irq_ack_i),
        .irq_valid_o   (irq_valid_o),
        .irq_id_o      (irq_id_o),
        .irq_level_o   (irq_level_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc++;
        if (cyc > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    //************************************************************
    // Reference model
    //************************************************************
    function automatic exp_t ref_pick();
        logic [`FC_N_SRC-1:0] act;
        exp_t                 r;
        act                   = '0;
        act[31:0]             = ev_m;
        act[`FC_SRC_SOC_EVT]  = soc_pend;
        act[`FC_SRC_TIMER]    = tmr_pend;
        act[`FC_SRC_EXT +: 3] = ext_m;
        r = '0;
        for (int i = 0; i < `FC_N_SRC; i++) begin
            // Only a strictly higher level displaces an earlier, lower id
            if (act[i] && en_m[i] && lvl_m[i] != 0) begin
                if (!r.valid || lvl_m[i] > r.req.level) begin
                    r.valid     = 1'b1;
                    r.req.id    = src_id_t'(i);
                    r.req.level = lvl_m[i];
                end
            end
        end
        return r;
    endfunction

    task automatic log_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    //************************************************************
    // Checker and core-side acknowledge
    //************************************************************
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            valid_q = 1'b0;
            hist1   = '0;
            hist2   = '0;
        end else begin
            // FSM latched two edges after the sources it reflects
            if (irq_valid_o && !valid_q) begin
                offer_cnt++;
                last_id  = irq_id_o;
                last_lvl = irq_level_o;
                if (!hist2.valid) begin
                    log_error($sformatf("offer of id %0d with no source pending", irq_id_o));
                end else if (irq_id_o !== hist2.req.id || irq_level_o !== hist2.req.level) begin
                    log_error($sformatf("offer id %0d level %0d, expected id %0d level %0d",
                        irq_id_o, irq_level_o, hist2.req.id, hist2.req.level));
                end
                ack_wait = $urandom % 4;
            end
            if (irq_ack_i) begin
                irq_ack_i <= #1 1'b0;
            end else if (irq_valid_o && !hold_ack) begin
                if (ack_wait == 0) begin
                    irq_ack_i <= #1 1'b1;
                end else begin
                    ack_wait--;
                end
            end
            valid_q = irq_valid_o;
            hist2   = hist1;
            hist1   = ref_pick();
        end
    end

    //************************************************************
    // Stimulus helpers entered and left 1 ns after an edge
    //************************************************************
    task automatic cfg_write(input int addr, input int data);
        cfg.wr   = 1'b1;
        cfg.addr = cfg_addr_t'(addr);
        cfg.data = cfg_data_t'(data);
        @(posedge clk_i);
        #1;
        cfg.wr = 1'b0;
        if (addr < `FC_N_SRC) begin
            en_m[addr]  = data[8];
            lvl_m[addr] = data[7:0];
        end else if (addr == `FC_ADDR_EVT_ID) begin
            watch_m = data[7:0];
        end
    endtask

    task automatic set_src(input int id, input logic en, input int lvl);
        cfg_write(id, (int'(en) << 8) | (lvl & 255));
    endtask

    task automatic set_lines(input logic [31:0] ev, input logic [2:0] ext);
        events_i  = ev;
        ext_irq_i = ext;
        ev_m      = ev;
        ext_m     = ext;
    endtask

    task automatic send_event(input int id);
        int n;
        event_valid_i = 1'b1;
        event_data_i  = event_id_t'(id);
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!event_ready_o && n < 20);
        #1;
        event_valid_i = 1'b0;
        if (n >= 20) begin
            $display("SoC event %0d was never accepted", id);
            err_cnt++;
        end else if (event_id_t'(id) == watch_m) begin
            soc_pend = 1'b1;
        end
    endtask

    task automatic wait_offer(input int limit);
        int start_cnt;
        int n;
        start_cnt = offer_cnt;
        n = 0;
        while (offer_cnt == start_cnt && n < limit) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (offer_cnt == start_cnt) begin
            $display("No interrupt offer arrived within %0d cycles", limit);
            err_cnt++;
        end
    endtask

    task automatic wait_idle();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 4 && n < 50) begin
            @(posedge clk_i);
            #1;
            quiet = irq_valid_o ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 4) begin
            $display("Interrupt offer did not go idle within 50 cycles");
            err_cnt++;
        end
    endtask

    //************************************************************
    // Tests
    //************************************************************
    task automatic check_reset_and_idle();
        if (irq_valid_o !== 1'b0 || irq_id_o !== '0 || irq_level_o !== '0) begin
            log_error("core-side outputs not at reset values");
        end
        if (event_ready_o !== 1'b1) begin
            log_error("event_ready_o low after reset");
        end
        repeat (24) begin
            set_lines($urandom, 3'($urandom));
            @(posedge clk_i);
            #1;
        end
        set_lines('0, '0);
        repeat (4) @(posedge clk_i);
        #1;
        if (offer_cnt != 0) begin
            log_error($sformatf("%0d offers with every source disabled", offer_cnt));
        end
    endtask

    task automatic check_single_line();
        int id;
        int lvl;
        id  = $urandom % 26;
        lvl = 1 + ($urandom % 255);
        set_src(id, 1'b1, lvl);
        hold_ack = 1'b1;
        set_lines(32'h1 << id, '0);
        @(posedge clk_i);
        #1;
        if (irq_valid_o !== 1'b0) begin
            log_error("irq_valid_o high one cycle after the line rose");
        end
        @(posedge clk_i);
        #1;
        if (irq_valid_o !== 1'b1 || irq_id_o !== src_id_t'(id) || irq_level_o !== lvl) begin
            log_error($sformatf("no offer of id %0d level %0d two cycles after the line",
                id, lvl));
        end
        repeat (5) begin
            @(posedge clk_i);
            #1;
            if (irq_valid_o !== 1'b1 || irq_id_o !== src_id_t'(id)) begin
                log_error("offer dropped or changed without acknowledge");
            end
        end
        hold_ack = 1'b0;
        set_lines('0, '0);
        wait_idle();
        set_src(id, 1'b0, 0);
    endtask

    task automatic check_priority();
        int a;
        int b;
        int c;
        int start;
        for (int r = 0; r < 4; r++) begin
            set_lines('0, '0);
            wait_idle();
            for (int i = 0; i < 32; i++) begin
                set_src(i, ($urandom % 4) != 0, $urandom % 250);
            end
            a = $urandom % 13;
            b = a + 1 + ($urandom % 12);
            c = 27 + ($urandom % 5);
            // Two equal top levels, plus a disabled source above both
            set_src(a, 1'b1, 8'hfe);
            set_src(b, 1'b1, 8'hfe);
            set_src(c, 1'b0, 8'hff);
            set_lines('1, '0);
            wait_offer(20);
            if (last_id !== src_id_t'(a) || last_lvl !== 8'hfe) begin
                log_error($sformatf("tie between ids %0d and %0d gave id %0d", a, b, last_id));
            end
            // Without the tied pair the random levels pick the winner
            set_src(a, 1'b0, 0);
            set_src(b, 1'b0, 0);
            wait_offer(20);
            wait_offer(20);
        end
        set_lines('0, '0);
        wait_idle();
        // Enabled at level 0 is still no candidate
        for (int i = 0; i < 32; i++) begin
            set_src(i, 1'b1, 0);
        end
        start = offer_cnt;
        set_lines('1, '0);
        repeat (6) @(posedge clk_i);
        #1;
        if (offer_cnt != start) begin
            log_error("source enabled at level 0 was offered");
        end
        set_lines('0, '0);
        for (int i = 0; i < 32; i++) begin
            set_src(i, 1'b0, 0);
        end
    endtask

    task automatic check_soc_event();
        int w;
        int start;
        w = 1 + ($urandom % 255);
        set_src(`FC_SRC_SOC_EVT, 1'b1, 1 + ($urandom % 255));
        cfg_write(`FC_ADDR_EVT_ID, w);
        start = offer_cnt;
        send_event(w ^ 8'h5a);
        if (event_ready_o !== 1'b1) begin
            log_error("event_ready_o dropped after an unwatched event");
        end
        repeat (6) @(posedge clk_i);
        #1;
        if (offer_cnt != start) begin
            log_error("unwatched event raised an interrupt");
        end
        send_event(w);
        if (event_ready_o !== 1'b0) begin
            log_error("event_ready_o still high with the event level pending");
        end
        wait_offer(20);
        if (last_id !== src_id_t'(`FC_SRC_SOC_EVT)) begin
            log_error($sformatf("SoC event offer carried id %0d", last_id));
        end
        cfg_write(`FC_ADDR_CLEAR, 1);
        @(posedge clk_i);
        #1;
        soc_pend = 1'b0;
        if (event_ready_o !== 1'b1) begin
            log_error("event_ready_o not restored by the clear");
        end
        wait_idle();
        start = offer_cnt;
        repeat (8) @(posedge clk_i);
        #1;
        if (offer_cnt != start) begin
            log_error("SoC event source still offered after the clear");
        end
        set_src(`FC_SRC_SOC_EVT, 1'b0, 0);
    endtask

    task automatic check_timer();
        int cval;
        int start;
        cval = 6 + ($urandom % 15);
        set_src(`FC_SRC_TIMER, 1'b1, 1 + ($urandom % 255));
        start = offer_cnt;
        cfg_write(`FC_ADDR_TIMER, cval);
        // First wrap falls exactly cval edges after the write took effect
        repeat (cval) @(posedge clk_i);
        #1;
        tmr_pend = 1'b1;
        if (offer_cnt != start) begin
            log_error("timer offer before compare cycles elapsed");
        end
        cfg_write(`FC_ADDR_CLEAR, 2);
        @(posedge clk_i);
        #1;
        tmr_pend = 1'b0;
        repeat (cval - 2) @(posedge clk_i);
        #1;
        tmr_pend = 1'b1;
        wait_offer(30);
        if (last_id !== src_id_t'(`FC_SRC_TIMER)) begin
            log_error($sformatf("timer offer carried id %0d", last_id));
        end
        cfg_write(`FC_ADDR_TIMER, 0);
        cfg_write(`FC_ADDR_CLEAR, 2);
        @(posedge clk_i);
        #1;
        tmr_pend = 1'b0;
        wait_idle();
        set_src(`FC_SRC_TIMER, 1'b0, 0);
    endtask

    task automatic check_ext_and_freeze();
        int lo;
        int hi;
        lo = 1 + ($urandom % 100);
        hi = 150 + ($urandom % 100);
        set_src(`FC_SRC_EXT, 1'b1, lo);
        set_src(`FC_SRC_EXT + 1, 1'b1, 1 + ($urandom % 255));
        set_src(`FC_SRC_EXT + 2, 1'b1, hi);
        for (int k = 0; k < 3; k++) begin
            set_lines('0, 3'b001 << k);
            wait_offer(20);
            if (last_id !== src_id_t'(`FC_SRC_EXT + k)) begin
                log_error($sformatf("external line %0d gave id %0d", k, last_id));
            end
            set_lines('0, '0);
            wait_idle();
        end
        hold_ack = 1'b1;
        set_lines('0, 3'b001);
        wait_offer(20);
        set_lines('0, 3'b101);
        repeat (6) @(posedge clk_i);
        #1;
        if (irq_valid_o !== 1'b1 || irq_id_o !== src_id_t'(`FC_SRC_EXT) ||
            irq_level_o !== lo) begin
            log_error("unacknowledged offer changed when a higher level arrived");
        end
        hold_ack = 1'b0;
        wait_offer(20);
        if (last_id !== src_id_t'(`FC_SRC_EXT + 2)) begin
            log_error($sformatf("offer after acknowledge carried id %0d", last_id));
        end
        set_lines('0, '0);
        wait_idle();
        for (int k = 0; k < 3; k++) begin
            set_src(`FC_SRC_EXT + k, 1'b0, 0);
        end
    endtask

    //************************************************************
    // Main sequence
    //************************************************************
    initial begin
        seed_val      = $urandom(SEED);
        arst_n_i      = 1'b0;
        cfg           = '0;
        event_valid_i = 1'b0;
        event_data_i  = '0;
        events_i      = '0;
        ext_irq_i     = '0;
        irq_ack_i     = 1'b0;
        hold_ack      = 1'b0;
        ack_wait      = 0;
        offer_cnt     = 0;
        err_cnt       = 0;
        ev_m          = '0;
        ext_m         = '0;
        soc_pend      = 1'b0;
        tmr_pend      = 1'b0;
        watch_m       = '0;
        for (int i = 0; i < `FC_N_SRC; i++) begin
            en_m[i]  = 1'b0;
            lvl_m[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        check_reset_and_idle();
        check_single_line();
        check_priority();
        check_soc_event();
        check_timer();
        check_ext_and_freeze();

        wait_idle();
        $display("Run complete: %0d offers checked, %0d errors", offer_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fc_irq_subsystem.sv
/*
 * Fabric controller interrupt front end
 * Builds the source vector and chains config, sources, arbiter and FSM
 */
`timescale 1ns/1ps
`default_nettype none

`include "fc_irq_cfg.svh"

module fc_irq_subsystem (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire fc_irq_pkg::cfg_wr_t    cfg_i,
    input  wire logic                   event_valid_i,
    input  wire fc_irq_pkg::event_id_t  event_data_i,
    output logic                        event_ready_o,
    input  wire logic [31:0]            events_i,
    input  wire logic [2:0]             ext_irq_i,
    input  wire logic                   irq_ack_i,
    output logic                        irq_valid_o,
    output fc_irq_pkg::src_id_t         irq_id_o,
    output fc_irq_pkg::irq_level_t      irq_level_o
);

    import fc_irq_pkg::*;

    src_cfg_t   src_cfg [`FC_N_SRC];
    timer_val_t timer_cmp;
    event_id_t  evt_id;
    logic       evt_clr;
    logic       timer_clr;
    logic       soc_evt_lvl;
    logic       timer_irq;
    src_vec_t   src_vec;
    logic       best_valid;
    irq_req_t   best;

    fc_irq_cfg_regs fc_irq_cfg_regs_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_i       (cfg_i),
        .src_cfg_o   (src_cfg),
        .timer_cmp_o (timer_cmp),
        .evt_id_o    (evt_id),
        .evt_clr_o   (evt_clr),
        .timer_clr_o (timer_clr)
    );

    event_to_level event_to_level_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .event_valid_i (event_valid_i),
        .event_data_i  (event_data_i),
        .evt_id_i      (evt_id),
        .clr_i         (evt_clr),
        .event_ready_o (event_ready_o),
        .int_lvl_o     (soc_evt_lvl)
    );

    fc_timer fc_timer_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cmp_i    (timer_cmp),
        .clr_i    (timer_clr),
        .irq_o    (timer_irq)
    );

    //************************************************************
    // Source vector
    //************************************************************
    always_comb begin
        src_vec                      = '0;
        src_vec[31:0]                = events_i;
        // SoC event level takes over plain line 26
        src_vec[`FC_SRC_SOC_EVT]     = soc_evt_lvl;
        src_vec[`FC_SRC_TIMER]       = timer_irq;
        src_vec[`FC_SRC_EXT +: 3]    = ext_irq_i;
    end

    irq_arbiter irq_arbiter_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .src_i        (src_vec),
        .src_cfg_i    (src_cfg),
        .best_valid_o (best_valid),
        .best_o       (best)
    );

    irq_notify_fsm irq_notify_fsm_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .best_valid_i (best_valid),
        .best_i       (best),
        .irq_ack_i    (irq_ack_i),
        .irq_valid_o  (irq_valid_o),
        .irq_id_o     (irq_id_o),
        .irq_level_o  (irq_level_o)
    );

endmodule

`default_nettype wire

//--- irq_notify_fsm.sv
/*
 * Core notification FSM
 * Offers the arbiter winner with valid/ack and holds it until acknowledged
 */
`timescale 1ns/1ps
`default_nettype none

module irq_notify_fsm (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   best_valid_i,
    input  wire fc_irq_pkg::irq_req_t   best_i,
    input  wire logic                   irq_ack_i,
    output logic                        irq_valid_o,
    output fc_irq_pkg::src_id_t         irq_id_o,
    output fc_irq_pkg::irq_level_t      irq_level_o
);

    import fc_irq_pkg::*;

    notify_state_e state_q;
    notify_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (best_valid_i) state_d = NOTIFY;
            NOTIFY:  if (irq_ack_i) state_d = SETTLE;
            // One spare cycle lets the arbiter catch up with cleared sources
            SETTLE:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            irq_id_o    <= '0;
            irq_level_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && best_valid_i) begin
                irq_id_o    <= best_i.id;
                irq_level_o <= best_i.level;
            end
        end
    end

    assign irq_valid_o = (state_q == NOTIFY);

    // Offer stays frozen until the core takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (irq_valid_o && !irq_ack_i) |=>
            (irq_valid_o && $stable(irq_id_o) && $stable(irq_level_o)))
        else $error("offer changed before acknowledge");

endmodule

`default_nettype wire

//--- irq_arbiter.sv
/*
 * Interrupt arbiter
 * Registers the enabled active source with the highest level,
 * lowest id first among equal levels
 */
`timescale 1ns/1ps
`default_nettype none

`include "fc_irq_cfg.svh"

module irq_arbiter (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire fc_irq_pkg::src_vec_t  src_i,
    input  wire fc_irq_pkg::src_cfg_t  src_cfg_i [`FC_N_SRC],
    output logic                       best_valid_o,
    output fc_irq_pkg::irq_req_t       best_o
);

    import fc_irq_pkg::*;

    irq_req_t best_d;
    logic     found;

    //************************************************************
    // Combinational scan
    //************************************************************
    always_comb begin
        best_d = '0;
        found  = 1'b0;
        // Ascending scan with a strict compare keeps the lowest id on ties
        for (int i = 0; i < `FC_N_SRC; i++) begin
            if (src_i[i] && src_cfg_i[i].en && (src_cfg_i[i].level > best_d.level)) begin
                best_d.id    = src_id_t'(i);
                best_d.level = src_cfg_i[i].level;
                found        = 1'b1;
            end
        end
    end

    //************************************************************
    // Result registers
    //************************************************************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            best_valid_o <= 1'b0;
            best_o       <= '0;
        end else begin
            best_valid_o <= found;
            best_o       <= best_d;
        end
    end

endmodule

`default_nettype wire

//--- fc_timer.sv
/*
 * Periodic timer
 * Counts 0 .. compare-1 and sets a sticky interrupt on each wrap
 */
`timescale 1ns/1ps
`default_nettype none

module fc_timer (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire fc_irq_pkg::timer_val_t cmp_i,
    input  wire logic                   clr_i,
    output logic                        irq_o
);

    import fc_irq_pkg::*;

    timer_val_t cnt_q;
    timer_val_t cmp_q;
    timer_val_t cnt_cur;
    logic       wrap;

    // A new compare value restarts the period from 0 on this edge
    assign cnt_cur = (cmp_i != cmp_q) ? '0 : cnt_q;
    assign wrap    = (cmp_i != '0) && (cnt_cur == cmp_i - timer_val_t'(1));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
            cmp_q <= '0;
        end else begin
            cmp_q <= cmp_i;
            if (cmp_i == '0 || wrap) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_cur + timer_val_t'(1);
            end
        end
    end

    // Sticky level
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else if (clr_i) begin
            irq_o <= 1'b0;
        end else if (wrap) begin
            irq_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- event_to_level.sv
/*
 * SoC event to level interrupt
 * The watched event id sets a pending level, other ids are dropped
 */
`timescale 1ns/1ps
`default_nettype none

module event_to_level (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  event_valid_i,
    input  wire fc_irq_pkg::event_id_t event_data_i,
    input  wire fc_irq_pkg::event_id_t evt_id_i,
    input  wire logic                  clr_i,
    output logic                       event_ready_o,
    output logic                       int_lvl_o
);

    logic accept;
    logic hit;

    // Stall the event stream until software clears the level
    assign event_ready_o = !int_lvl_o;
    assign accept        = event_valid_i && event_ready_o;
    assign hit           = accept && (event_data_i == evt_id_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            int_lvl_o <= 1'b0;
        end else if (clr_i) begin
            // clear wins over a set on the same edge
            int_lvl_o <= 1'b0;
        end else if (hit) begin
            int_lvl_o <= 1'b1;
        end
    end

    // Once pending, nothing gets through until a clear
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (int_lvl_o && !clr_i) |=> !(event_valid_i && event_ready_o))
        else $error("event accepted while level pending");

endmodule

`default_nettype wire

//--- fc_irq_cfg_regs.sv
/*
 * Configuration register file
 * Decodes write strobes into per-source enable/level entries, the timer
 * compare value, the watched event id and one-cycle clear pulses
 */
`timescale 1ns/1ps
`default_nettype none

`include "fc_irq_cfg.svh"

module fc_irq_cfg_regs (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire fc_irq_pkg::cfg_wr_t  cfg_i,
    output fc_irq_pkg::src_cfg_t      src_cfg_o [`FC_N_SRC],
    output fc_irq_pkg::timer_val_t    timer_cmp_o,
    output fc_irq_pkg::event_id_t     evt_id_o,
    output logic                      evt_clr_o,
    output logic                      timer_clr_o
);

    import fc_irq_pkg::*;

    src_id_t wr_src;
    logic    src_hit;
    logic    clr_hit;

    assign wr_src  = cfg_i.addr[`FC_SRC_ID_W-1:0];
    assign src_hit = cfg_i.wr && (cfg_i.addr < cfg_addr_t'(`FC_N_SRC));
    assign clr_hit = cfg_i.wr && (cfg_i.addr == cfg_addr_t'(`FC_ADDR_CLEAR));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `FC_N_SRC; i++) begin
                src_cfg_o[i] <= '0;
            end
            timer_cmp_o <= '0;
            evt_id_o    <= '0;
            evt_clr_o   <= 1'b0;
            timer_clr_o <= 1'b0;
        end else begin
            if (src_hit) begin
                src_cfg_o[wr_src].en    <= cfg_i.data[`FC_LEVEL_W];
                src_cfg_o[wr_src].level <= cfg_i.data[`FC_LEVEL_W-1:0];
            end
            if (cfg_i.wr && cfg_i.addr == cfg_addr_t'(`FC_ADDR_TIMER)) begin
                timer_cmp_o <= cfg_i.data[`FC_TIMER_W-1:0];
            end
            if (cfg_i.wr && cfg_i.addr == cfg_addr_t'(`FC_ADDR_EVT_ID)) begin
                evt_id_o <= cfg_i.data[`FC_EVENT_W-1:0];
            end
            evt_clr_o   <= clr_hit && cfg_i.data[0];
            timer_clr_o <= clr_hit && cfg_i.data[1];
        end
    end

    // Clear strobes toward event and timer blocks are pulses
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (evt_clr_o |=> !evt_clr_o) and (timer_clr_o |=> !timer_clr_o))
        else $error("clear pulse held longer than one cycle");

endmodule

`default_nettype wire

//--- fc_irq_pkg.sv
/*
 * Interrupt front end types
 * Width typedefs, bundled port structs and the notification state enum
 */
`default_nettype none

`include "fc_irq_cfg.svh"

package fc_irq_pkg;

    typedef logic [`FC_SRC_ID_W-1:0] src_id_t;
    typedef logic [`FC_LEVEL_W-1:0]  irq_level_t;
    typedef logic [`FC_EVENT_W-1:0]  event_id_t;
    typedef logic [`FC_TIMER_W-1:0]  timer_val_t;
    typedef logic [6:0]              cfg_addr_t;
    typedef logic [31:0]             cfg_data_t;
    typedef logic [`FC_N_SRC-1:0]    src_vec_t;

    // Single-cycle configuration write
    typedef struct packed {
        logic      wr;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_wr_t;

    // Per-source setting
    typedef struct packed {
        logic       en;
        irq_level_t level;
    } src_cfg_t;

    // Selected interrupt
    typedef struct packed {
        src_id_t    id;
        irq_level_t level;
    } irq_req_t;

    typedef enum logic [1:0] {
        IDLE,
        NOTIFY,
        SETTLE
    } notify_state_e;

endpackage

`default_nettype wire

//--- fc_irq_cfg.svh
/*
 * Interrupt front end configuration
 * Source count, field widths, register map and fixed source positions
 */
`ifndef FC_IRQ_CFG_SVH
`define FC_IRQ_CFG_SVH

// Sizes
`define FC_N_SRC        64
`define FC_SRC_ID_W     6
`define FC_LEVEL_W      8
`define FC_EVENT_W      8
`define FC_TIMER_W      16

// Register map above the per-source entries
`define FC_ADDR_TIMER   64
`define FC_ADDR_CLEAR   65
`define FC_ADDR_EVT_ID  66

// Fixed positions in the source vector
`define FC_SRC_SOC_EVT  26
`define FC_SRC_TIMER    32
`define FC_SRC_EXT      33

`endif
